// File: Makefile
# Verilator build and run for the palette video stage

VERILATOR ?= verilator
TOP       ?= paletteVideoTb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "Failure reported in $(LOG)"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/neoVideoPkg.sv
/* Palette video shared types */

package neoVideoPkg;

	// ========================================
	// Widths
	// ========================================

	// Palette index inside one bank
	localparam int PAL_INDEX_W = 12;
	// Bank select bits above the index
	localparam int PAL_BANKS_LOG2 = 1;
	// Stored colour word
	localparam int COLOR_W = 16;
	// One output channel
	localparam int CHAN_W = 8;

	// ========================================
	// CPU write side
	// ========================================

	// Which block owns a write strobe
	typedef enum logic {
		writePalette = 1'b0,
		writeLatch   = 1'b1
	} busTarget_e;

	// One-cycle write request, no acknowledge
	typedef struct packed {
		logic                   strobe;
		busTarget_e             target;
		logic [PAL_INDEX_W-1:0] addr;
		logic [COLOR_W-1:0]     data;
	} cpuWrite_t;

	// ========================================
	// Pixel side
	// ========================================

	// Renderer output for one pixel
	typedef struct packed {
		logic [PAL_INDEX_W-1:0] palIndex;
		// Horizontal blank
		logic                   chbl;
		// Vertical blank, low while blanking
		logic                   nBnkb;
	} pixelIn_t;

	// Final 8-bit colour
	typedef struct packed {
		logic [CHAN_W-1:0] red;
		logic [CHAN_W-1:0] green;
		logic [CHAN_W-1:0] blue;
	} rgb_t;

endpackage

// File: design/paletteRam.sv
/* Two-bank palette RAM */

`timescale 1ns/1ps

module paletteRam (
	input  logic                  CLK_48M,
	input  neoVideoPkg::cpuWrite_t cpuWr,
	input  logic                  cpuBank,
	input  logic [neoVideoPkg::PAL_BANKS_LOG2+neoVideoPkg::PAL_INDEX_W-1:0] rdAddr,
	output logic [neoVideoPkg::COLOR_W-1:0] rdData
);
	import neoVideoPkg::*;

	localparam int ADDR_W = PAL_BANKS_LOG2 + PAL_INDEX_W;
	localparam int DEPTH  = 1 << ADDR_W;

	// Colour store, both banks back to back
	logic [COLOR_W-1:0] mem [DEPTH];

	logic [ADDR_W-1:0] wrAddr;
	logic              wrEn;

	// Bank bit on top of the CPU index
	assign wrAddr = {cpuBank, cpuWr.addr};
	assign wrEn   = cpuWr.strobe && (cpuWr.target == writePalette);

	// ========================================
	// CPU write port
	// ========================================

	always_ff @(posedge CLK_48M) begin
		if (wrEn) begin
			mem[wrAddr] <= cpuWr.data;
		end
	end

	// ========================================
	// Pixel read port
	// ========================================

	// One cycle from address to data
	always_ff @(posedge CLK_48M) begin
		rdData <= mem[rdAddr];
	end

endmodule

// File: design/paletteVideoTop.sv
/* Palette video output stage */

`timescale 1ns/1ps

module paletteVideoTop #(
	parameter int PIXEL_DIV = 8
) (
	input  logic                  CLK_48M,
	input  logic                  nRESET,
	input  neoVideoPkg::cpuWrite_t cpuWr,
	input  neoVideoPkg::pixelIn_t pixIn,
	output neoVideoPkg::rgb_t     rgb,
	output logic                  hblank,
	output logic                  vblank,
	output logic                  cePixel
);
	import neoVideoPkg::*;

	// Latch outputs
	logic shadow;
	logic palBank;

	// Palette read path
	logic [PAL_BANKS_LOG2+PAL_INDEX_W-1:0] rdAddr;
	logic [COLOR_W-1:0]                    rdData;

	// ========================================
	// Control bits
	// ========================================

	systemLatch i_systemLatch (
		.CLK_48M (CLK_48M),
		.nRESET  (nRESET),
		.cpuWr   (cpuWr),
		.shadow  (shadow),
		.palBank (palBank)
	);

	// ========================================
	// Palette memory
	// ========================================

	// CPU writes land in the bank the latch selects
	paletteRam i_paletteRam (
		.CLK_48M (CLK_48M),
		.cpuWr   (cpuWr),
		.cpuBank (palBank),
		.rdAddr  (rdAddr),
		.rdData  (rdData)
	);

	// ========================================
	// Pixel path
	// ========================================

	pixelPipeline #(
		.PIXEL_DIV (PIXEL_DIV)
	) i_pixelPipeline (
		.CLK_48M (CLK_48M),
		.nRESET  (nRESET),
		.pixIn   (pixIn),
		.palBank (palBank),
		.shadow  (shadow),
		.rdAddr  (rdAddr),
		.rdData  (rdData),
		.cePixel (cePixel),
		.rgb     (rgb),
		.hblank  (hblank),
		.vblank  (vblank)
	);

endmodule

// File: design/pixelPipeline.sv
/* Pixel enable and colour pipeline */

`timescale 1ns/1ps

module pixelPipeline #(
	parameter int PIXEL_DIV = 8
) (
	input  logic                  CLK_48M,
	input  logic                  nRESET,
	input  neoVideoPkg::pixelIn_t pixIn,
	input  logic                  palBank,
	input  logic                  shadow,
	output logic [neoVideoPkg::PAL_BANKS_LOG2+neoVideoPkg::PAL_INDEX_W-1:0] rdAddr,
	input  logic [neoVideoPkg::COLOR_W-1:0] rdData,
	output logic                  cePixel,
	output neoVideoPkg::rgb_t     rgb,
	output logic                  hblank,
	output logic                  vblank
);
	import neoVideoPkg::*;

	localparam int CNT_W = (PIXEL_DIV > 2) ? $clog2(PIXEL_DIV) : 1;

	// Divider state
	logic [CNT_W-1:0] divCnt;

	// Blank delay stages
	logic chblD1;
	logic chblD2;
	logic vblankD1;

	// Converted colour of the fetched word
	rgb_t rgbNext;
	logic dark;

	// Expand one 5-bit channel plus dark to 8 bits
	function automatic logic [CHAN_W-1:0] expandChannel(
		input logic [3:0] hi,
		input logic       lo,
		input logic       darkBit,
		input logic       shade
	);
		logic [6:0]        diff;
		logic [5:0]        v;
		logic [CHAN_W-1:0] full;
		// Channel bits, low bit, then top bit repeated
		diff = {1'b0, hi, lo, hi[3]} - {6'd0, darkBit};
		// Borrow out means it went below zero
		v = diff[6] ? 6'd0 : diff[5:0];
		full = {v, v[4:3]};
		// Shadow halves the level
		return shade ? {1'b0, full[CHAN_W-1:1]} : full;
	endfunction

	// ========================================
	// 6 MHz pixel enable
	// ========================================

	// Registered so the first pulse lands on cycle PIXEL_DIV
	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			divCnt  <= '0;
			cePixel <= 1'b0;
		end else begin
			cePixel <= (divCnt == CNT_W'(PIXEL_DIV - 2));
			if (divCnt == CNT_W'(PIXEL_DIV - 1)) begin
				divCnt <= '0;
			end else begin
				divCnt <= divCnt + 1'b1;
			end
		end
	end

	// ========================================
	// Colour conversion
	// ========================================

	// Bit 15 darkens all three channels
	assign dark = rdData[15];

	always_comb begin
		// Low bits sit at 14, 13, 12 for R, G, B
		rgbNext.red   = expandChannel(rdData[11:8], rdData[14], dark, shadow);
		rgbNext.green = expandChannel(rdData[7:4], rdData[13], dark, shadow);
		rgbNext.blue  = expandChannel(rdData[3:0], rdData[12], dark, shadow);
	end

	// ========================================
	// Pipeline registers
	// ========================================

	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			rdAddr   <= '0;
			chblD1   <= 1'b0;
			chblD2   <= 1'b0;
			vblankD1 <= 1'b0;
			rgb      <= '0;
			hblank   <= 1'b0;
			vblank   <= 1'b0;
		end else if (cePixel) begin
			// Stage 1, fetch address with the bank in force now
			rdAddr   <= {palBank, pixIn.palIndex};
			vblankD1 <= ~pixIn.nBnkb;
			chblD1   <= pixIn.chbl;
			// Stage 2, RAM word has been ready for several cycles
			rgb      <= rgbNext;
			vblank   <= vblankD1;
			chblD2   <= chblD1;
			// hblank trails by one more pixel
			hblank   <= chblD2;
		end
	end

endmodule

// File: design/systemLatch.sv
/* System control latch */

`timescale 1ns/1ps

module systemLatch (
	input  logic                  CLK_48M,
	input  logic                  nRESET,
	input  neoVideoPkg::cpuWrite_t cpuWr,
	output logic                  shadow,
	output logic                  palBank
);
	import neoVideoPkg::*;

	// Bit index and value taken from the low address bits
	logic [2:0] bitSel;
	logic       bitVal;
	logic       latchWr;

	assign bitSel  = cpuWr.addr[2:0];
	assign bitVal  = cpuWr.addr[3];
	// Only strobes aimed at the latch count
	assign latchWr = cpuWr.strobe && (cpuWr.target == writeLatch);

	// ========================================
	// Addressed bit latch
	// ========================================

	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			shadow  <= 1'b0;
			palBank <= 1'b0;
		end else if (latchWr) begin
			case (bitSel)
				// Bit 0 halves the output colour
				3'd0: begin
					shadow <= bitVal;
				end
				// Bit 7 picks the palette bank
				3'd7: begin
					palBank <= bitVal;
				end
				// Remaining bits steer nothing here
				default: begin
				end
			endcase
		end
	end

endmodule

// File: sim.f
design/neoVideoPkg.sv
design/systemLatch.sv
design/paletteRam.sv
design/pixelPipeline.sv
design/paletteVideoTop.sv
tb/paletteVideo_props.sv
tb/paletteVideoTb.sv

// File: tb/paletteVideoTb.sv
/* Palette video testbench */

`timescale 1ns/1ps

module paletteVideoTb;
	import neoVideoPkg::*;

	localparam int PIXEL_DIV = 8;
	localparam int RESET_CYCLES = 16;
	// Pixel steps and bus writes issued by all tests together
	localparam int STEP_COUNT = 64;
	localparam int WRITE_COUNT = 31;
	localparam int TEST_CYCLES = RESET_CYCLES + (4 + STEP_COUNT) * PIXEL_DIV + 2 * WRITE_COUNT;
	localparam int TIMEOUT_CYCLES = TEST_CYCLES * 3 / 2;

	logic      CLK_48M;
	logic      nRESET;
	cpuWrite_t cpuWr;
	pixelIn_t  pixIn;
	rgb_t      rgb;
	logic      hblank;
	logic      vblank;
	logic      cePixel;

	// Palette and latch contents as the writes left them
	logic [COLOR_W-1:0] palModel [1 << (PAL_BANKS_LOG2 + PAL_INDEX_W)];
	logic               shadowModel;
	logic               bankModel;
	// One entry per pixel sent since the last bus write
	logic [COLOR_W-1:0] colourHist [$];
	logic               chblHist [$];
	logic               vblHist [$];

	logic [31:0] rngState;
	int          errRgb;
	int          errBlank;
	int          errEnable;
	int          cycleCount = 0;

	paletteVideoTop #(.PIXEL_DIV(PIXEL_DIV)) i_dut (.*);

	always #4 CLK_48M = ~CLK_48M;

	// ========================================
	// Timeout
	// ========================================

	always @(posedge CLK_48M) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the tests did not finish", cycleCount);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// ========================================
	// Reference model
	// ========================================

	function automatic logic [31:0] nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	// One channel by the conversion rule, clamped in signed math
	function automatic logic [CHAN_W-1:0] refChannel(
		input logic [3:0] bits4, input logic lowBit, input logic darkBit, input logic shade);
		int         level;
		logic [5:0] v;
		logic [7:0] wide;
		level = int'({bits4, lowBit, bits4[3]}) - int'(darkBit);
		v = (level < 0) ? 6'd0 : 6'(level);
		wide = {v, v[4:3]};
		return shade ? (wide >> 1) : wide;
	endfunction

	function automatic rgb_t refColour(input logic [COLOR_W-1:0] word, input logic shade);
		rgb_t c;
		c.red   = refChannel(word[11:8], word[14], word[15], shade);
		c.green = refChannel(word[7:4], word[13], word[15], shade);
		c.blue  = refChannel(word[3:0], word[12], word[15], shade);
		return c;
	endfunction

	// ========================================
	// Compare tasks
	// ========================================

	task automatic checkRgb(input rgb_t got, input rgb_t exp, input string what);
		if (got !== exp) begin
			errRgb++;
			$display("CHECK FAILED at time %0t: %s rgb %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkBlank(input logic gotH, input logic gotV, input logic expH,
		input logic expV, input string what);
		if ({gotH, gotV} !== {expH, expV}) begin
			errBlank++;
			$display("CHECK FAILED at time %0t: %s hblank/vblank %b%b expected %b%b",
				$time, what, gotH, gotV, expH, expV);
		end
	endtask

	task automatic expectEnable(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			errEnable++;
			$display("CHECK FAILED at time %0t: %s cePixel %b expected %b", $time, what, got, exp);
		end
	endtask

	// ========================================
	// Bus and pixel drivers
	// ========================================

	task automatic busWrite(input busTarget_e target, input logic [PAL_INDEX_W-1:0] addr,
		input logic [COLOR_W-1:0] data);
		@(negedge CLK_48M);
		cpuWr.strobe = 1'b1;
		cpuWr.target = target;
		cpuWr.addr   = addr;
		cpuWr.data   = data;
		@(negedge CLK_48M);
		cpuWr.strobe = 1'b0;
		// Pixels in flight may predate the write
		colourHist.delete();
		chblHist.delete();
		vblHist.delete();
	endtask

	// Palette write lands in the bank selected before it
	task automatic storeColour(input logic [PAL_INDEX_W-1:0] idx, input logic [COLOR_W-1:0] colour);
		busWrite(writePalette, idx, colour);
		palModel[{bankModel, idx}] = colour;
	endtask

	// Bit index in addr[2:0], value in addr[3]
	task automatic setLatchBit(input logic [2:0] sel, input logic val);
		busWrite(writeLatch, {8'd0, val, sel}, '0);
		if (sel == 3'd0) shadowModel = val;
		if (sel == 3'd7) bankModel = val;
	endtask

	task automatic sendPixel(input logic [PAL_INDEX_W-1:0] idx, input logic chbl, input logic nBnkb);
		int n;
		@(negedge CLK_48M);
		while (cePixel !== 1'b1) @(negedge CLK_48M);
		n = colourHist.size();
		// Colour and vblank trail by two pixels here, hblank by three
		if (n >= 2) checkRgb(rgb, refColour(colourHist[n-2], shadowModel), "pixel colour");
		if (n >= 3) checkBlank(hblank, vblank, chblHist[n-3], vblHist[n-2], "blank delay");
		pixIn.palIndex = idx;
		pixIn.chbl     = chbl;
		pixIn.nBnkb    = nBnkb;
		colourHist.push_back(palModel[{bankModel, idx}]);
		chblHist.push_back(chbl);
		vblHist.push_back(~nBnkb);
	endtask

	// Filler pixels push the last real ones out
	task automatic flushPipe();
		repeat (3) sendPixel('0, 1'b0, 1'b1);
	endtask

	// ========================================
	// Directed tests
	// ========================================

	task automatic resetAndEnable();
		int c;
		nRESET = 1'b0;
		repeat (RESET_CYCLES) @(negedge CLK_48M);
		checkRgb(rgb, '0, "rgb in reset");
		checkBlank(hblank, vblank, 1'b0, 1'b0, "blank in reset");
		nRESET = 1'b1;
		// Negedge c falls in cycle c+1 after release
		for (c = 1; c <= 4 * PIXEL_DIV; c++) begin
			@(negedge CLK_48M);
			expectEnable(cePixel, ((c + 1) % PIXEL_DIV) == 0, "enable spacing");
			if (c < PIXEL_DIV) checkRgb(rgb, '0, "rgb before first pixel");
			checkBlank(hblank, vblank, 1'b0, 1'b0, "blank after reset");
		end
	endtask

	task automatic colourLookup();
		logic [PAL_INDEX_W-1:0] idx [12];
		// Index 0 stays reserved for filler
		foreach (idx[i]) begin
			idx[i] = PAL_INDEX_W'(nextRandom() % 4095 + 1);
			storeColour(idx[i], COLOR_W'(nextRandom()));
		end
		foreach (idx[i]) sendPixel(idx[i], 1'b0, 1'b1);
		flushPipe();
	endtask

	task automatic darkClamp();
		logic [COLOR_W-1:0] colours [5];
		// Dark with zero channels, all ones, and small channels near the clamp
		colours = '{16'h8000, 16'hffff, 16'h8f00, 16'hb0f0, 16'h9001};
		foreach (colours[i]) storeColour(PAL_INDEX_W'(i + 16), colours[i]);
		foreach (colours[i]) sendPixel(PAL_INDEX_W'(i + 16), 1'b0, 1'b1);
		flushPipe();
	endtask

	task automatic shadowHalving();
		storeColour(12'h123, 16'h7fff);
		storeColour(12'h124, 16'h2a5c);
		setLatchBit(3'd0, 1'b1);
		repeat (2) begin
			sendPixel(12'h123, 1'b0, 1'b1);
			sendPixel(12'h124, 1'b0, 1'b1);
		end
		flushPipe();
		// Full levels come back once shadow clears
		setLatchBit(3'd0, 1'b0);
		repeat (2) begin
			sendPixel(12'h123, 1'b0, 1'b1);
			sendPixel(12'h124, 1'b0, 1'b1);
		end
		flushPipe();
	endtask

	task automatic bankSelect();
		storeColour(12'h0a5, 16'h0f00);
		setLatchBit(3'd7, 1'b1);
		storeColour(12'h0a5, 16'h00f0);
		repeat (3) sendPixel(12'h0a5, 1'b0, 1'b1);
		flushPipe();
		setLatchBit(3'd7, 1'b0);
		repeat (3) sendPixel(12'h0a5, 1'b0, 1'b1);
		flushPipe();
		// Bits other than 0 and 7 steer nothing
		setLatchBit(3'd3, 1'b1);
		setLatchBit(3'd5, 1'b1);
		repeat (3) sendPixel(12'h0a5, 1'b0, 1'b1);
		flushPipe();
	endtask

	task automatic blankDelay();
		// One-pixel hblank pulse, later one pixel of vertical blank
		sendPixel('0, 1'b0, 1'b1);
		sendPixel('0, 1'b1, 1'b1);
		sendPixel('0, 1'b0, 1'b1);
		sendPixel('0, 1'b0, 1'b0);
		sendPixel('0, 1'b0, 1'b1);
		sendPixel('0, 1'b0, 1'b1);
		flushPipe();
	endtask

	// ========================================
	// Main sequence
	// ========================================

	initial begin
		CLK_48M = 1'b0;
		nRESET = 1'b0;
		cpuWr = '0;
		pixIn = '0;
		pixIn.nBnkb = 1'b1;
		rngState = 32'h3a2d_7053;
		shadowModel = 1'b0;
		bankModel = 1'b0;
		errRgb = 0;
		errBlank = 0;
		errEnable = 0;
		resetAndEnable();
		// Known filler colour at index 0 in both banks
		storeColour('0, 16'h4210);
		setLatchBit(3'd7, 1'b1);
		storeColour('0, 16'h0c63);
		setLatchBit(3'd7, 1'b0);
		colourLookup();
		darkClamp();
		shadowHalving();
		bankSelect();
		blankDelay();
		$display("Errors: rgb %0d, blank %0d, enable %0d", errRgb, errBlank, errEnable);
		if (errRgb + errBlank + errEnable == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: tb/paletteVideo_props.sv
/* Pixel timing assertions */

`timescale 1ns/1ps

module paletteVideoProps #(
	parameter int PIXEL_DIV = 8
) (
	input logic              CLK_48M,
	input logic              nRESET,
	input logic              cePixel,
	input neoVideoPkg::rgb_t rgb,
	input logic              hblank,
	input logic              vblank
);

	// Enable lasts exactly one cycle
	assert property (@(posedge CLK_48M) disable iff (!nRESET) cePixel |=> !cePixel)
		else $error("cePixel stayed high for more than one cycle");

	// Next enable comes PIXEL_DIV cycles later
	assert property (@(posedge CLK_48M) disable iff (!nRESET)
		$past(cePixel, PIXEL_DIV) |-> cePixel)
		else $error("cePixel did not repeat after PIXEL_DIV cycles");

	// Outputs move only on the edge that follows an enable
	assert property (@(posedge CLK_48M) disable iff (!nRESET)
		!$past(cePixel) |-> ($stable(rgb) && $stable(hblank) && $stable(vblank)))
		else $error("video outputs changed without a pixel enable");

	// Colour held at zero through reset
	assert property (@(posedge CLK_48M) !nRESET |=> rgb == '0)
		else $error("rgb not zero during reset");

endmodule

bind pixelPipeline paletteVideoProps #(
	.PIXEL_DIV (PIXEL_DIV)
) i_props (
	.CLK_48M (CLK_48M),
	.nRESET  (nRESET),
	.cePixel (cePixel),
	.rgb     (rgb),
	.hblank  (hblank),
	.vblank  (vblank)
);
